// ==== Bender.yml ====
package:
  name: ipf

sources:
  - files:
      - hw/ipf_pkg.sv
      - hw/lcu_pixel_buffer.sv
      - hw/ipf_scan_ctrl.sv
      - hw/ipf_sample_filter.sv
      - hw/ipf_top.sv
  - target: test
    files:
      - testbench/ipf_properties.sv
      - testbench/ipf_tb.sv

// ==== build.f ====
hw/ipf_pkg.sv
hw/lcu_pixel_buffer.sv
hw/ipf_scan_ctrl.sv
hw/ipf_sample_filter.sv
hw/ipf_top.sv
testbench/ipf_properties.sv
testbench/ipf_tb.sv

// ==== hw/ipf_pkg.sv ====
`default_nettype none

package ipf_pkg;

    // ------------------------------------------------------------------------
    // sample and address geometry
    // ------------------------------------------------------------------------
    localparam int pixel_w    = 8;
    localparam int addr_w     = 14;
    localparam int img_width  = 128;     // picture width in samples
    localparam int offset_w   = 4;       // one signed offset nibble
    localparam int band_shift = 3;       // 256 levels -> 32 bands

    typedef logic [pixel_w-1:0]         pixel_t;
    typedef logic [addr_w-1:0]          addr_t;
    typedef logic signed [offset_w-1:0] offset_t;

    // ------------------------------------------------------------------------
    // filter mode as carried on ipf_type
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        ipf_off     = 2'd0,
        ipf_band    = 2'd1,
        ipf_edge    = 2'd2,
        ipf_off_alt = 2'd3              // behaves as off
    } ipf_mode_t;

    // edge classes whose low two bits pick the offset nibble
    typedef enum logic [2:0] {
        cat_min     = 3'd0,
        cat_concave = 3'd1,
        cat_convex  = 3'd2,
        cat_max     = 3'd3,
        cat_none    = 3'd4
    } edge_cat_t;

endpackage

`default_nettype wire

// ==== hw/ipf_sample_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipf_sample_filter (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  issue,
    input  wire logic                  at_first,
    input  wire logic                  at_last,
    input  wire ipf_pkg::ipf_mode_t    mode,
    input  wire logic                  wo_class,
    input  wire logic [4:0]            band_pos,
    input  wire logic [15:0]           offsets,
    input  wire ipf_pkg::addr_t        issue_addr,
    input  wire ipf_pkg::pixel_t       centre,
    input  wire ipf_pkg::pixel_t       left,
    input  wire ipf_pkg::pixel_t       right,
    input  wire ipf_pkg::pixel_t       up,
    input  wire ipf_pkg::pixel_t       down,
    output logic                       out_en,
    output ipf_pkg::pixel_t            dout,
    output ipf_pkg::addr_t             dout_addr
);

    localparam int band_w = ipf_pkg::pixel_w - ipf_pkg::band_shift;

    ipf_pkg::pixel_t                    nb_a;
    ipf_pkg::pixel_t                    nb_b;
    logic [ipf_pkg::pixel_w:0]          twice_c;
    logic [ipf_pkg::pixel_w:0]          pair_sum;
    ipf_pkg::edge_cat_t                 cat;

    logic [band_w-1:0]                  band;
    logic [band_w:0]                    band_rel;
    logic                               band_hit;

    logic                               apply;
    logic [1:0]                         sel_idx;
    ipf_pkg::offset_t                   off_sel;
    logic signed [ipf_pkg::pixel_w+1:0] sum_wide;
    ipf_pkg::pixel_t                    result;

    // ------------------------------------------------------------------------
    // edge class
    // ------------------------------------------------------------------------
    assign nb_a     = wo_class ? up   : left;     // 1 = vertical pair
    assign nb_b     = wo_class ? down : right;
    assign twice_c  = {centre, 1'b0};
    assign pair_sum = {1'b0, nb_a} + {1'b0, nb_b};

    always_comb begin
        if (at_first || at_last) begin
            cat = ipf_pkg::cat_none;              // one neighbour missing
        end else if (centre < nb_a && centre < nb_b) begin
            cat = ipf_pkg::cat_min;
        end else if (centre > nb_a && centre > nb_b) begin
            cat = ipf_pkg::cat_max;
        end else if (twice_c < pair_sum) begin
            cat = ipf_pkg::cat_concave;
        end else if (twice_c > pair_sum) begin
            cat = ipf_pkg::cat_convex;
        end else begin
            cat = ipf_pkg::cat_none;
        end
    end

    // ------------------------------------------------------------------------
    // band match over four bands from band_pos without wrap past band 31
    // ------------------------------------------------------------------------
    assign band     = band_w'(centre >> ipf_pkg::band_shift);
    assign band_rel = {1'b0, band} - {1'b0, band_pos};
    assign band_hit = (band_rel < (band_w+1)'(4));

    // ------------------------------------------------------------------------
    // offset pick, add and clip
    // ------------------------------------------------------------------------
    always_comb begin
        case (mode)
            ipf_pkg::ipf_band: begin
                apply   = band_hit;
                sel_idx = band_rel[1:0];
            end
            ipf_pkg::ipf_edge: begin
                apply   = (cat != ipf_pkg::cat_none);
                sel_idx = cat[1:0];
            end
            default: begin                        // off and its alias
                apply   = 1'b0;
                sel_idx = 2'd0;
            end
        endcase
    end

    // offset 0 sits in the top nibble
    assign off_sel = ipf_pkg::offset_t'(
        offsets[ipf_pkg::offset_w*(3-sel_idx) +: ipf_pkg::offset_w]);

    assign sum_wide = $signed({2'b00, centre}) + off_sel;

    always_comb begin
        if (!apply) begin
            result = centre;
        end else if (sum_wide < 0) begin
            result = '0;
        end else if (sum_wide > 255) begin
            result = '1;
        end else begin
            result = sum_wide[ipf_pkg::pixel_w-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // output register one cycle after issue
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en <= 1'b0;
        end else begin
            out_en <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            dout      <= result;
            dout_addr <= issue_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ipf_scan_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipf_scan_ctrl #(
    parameter int lcu_side = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          first_write,
    input  wire logic                          load_done,
    input  wire logic [1:0]                    ipf_type,
    input  wire logic [4:0]                    ipf_band_pos,
    input  wire logic                          ipf_wo_class,
    input  wire logic [15:0]                   ipf_offset,
    input  wire logic [2:0]                    lcu_x,
    input  wire logic [2:0]                    lcu_y,
    output logic                               busy,
    output logic                               finish,
    output logic                               load_done_ack,
    output logic                               issue,
    output logic                               at_first,
    output logic                               at_last,
    output logic [$clog2(lcu_side)-1:0]        rd_row,
    output logic [$clog2(lcu_side)-1:0]        rd_col,
    output ipf_pkg::addr_t                     issue_addr,
    output ipf_pkg::ipf_mode_t                 mode,
    output logic                               wo_class,
    output logic [4:0]                         band_pos,
    output logic [15:0]                        offsets
);

    localparam int coord_w = $clog2(lcu_side);

    localparam logic [coord_w-1:0] last_coord = coord_w'(lcu_side - 1);
    localparam ipf_pkg::addr_t     side_a     = ipf_pkg::addr_t'(lcu_side);
    localparam ipf_pkg::addr_t     width_a    = ipf_pkg::addr_t'(ipf_pkg::img_width);

    typedef enum logic {
        st_load,
        st_proc
    } state_t;

    state_t         state;
    logic           start;                    // gap cycle before the first issue
    logic           scan_end;
    logic [2:0]     lcu_x_q;
    logic [2:0]     lcu_y_q;
    ipf_pkg::addr_t top_row;

    assign busy          = (state == st_proc);
    assign load_done_ack = finish;
    assign scan_end      = (rd_row == last_coord) && (rd_col == last_coord);

    // ------------------------------------------------------------------------
    // configuration sampled with the first accepted sample
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (first_write) begin
            wo_class <= ipf_wo_class;
            band_pos <= ipf_band_pos;
            offsets  <= ipf_offset;
            lcu_x_q  <= lcu_x;
            lcu_y_q  <= lcu_y;
        end
    end

    // ------------------------------------------------------------------------
    // load / process FSM and raster counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_load;
            start  <= 1'b0;
            issue  <= 1'b0;
            finish <= 1'b0;
            rd_row <= '0;
            rd_col <= '0;
            mode   <= ipf_pkg::ipf_off;
        end else begin
            start  <= 1'b0;
            finish <= issue && scan_end;      // lands with the last out_en
            if (first_write) begin
                mode <= ipf_pkg::ipf_mode_t'(ipf_type);
            end
            case (state)
                st_load: begin
                    if (load_done) begin
                        state  <= st_proc;
                        start  <= 1'b1;
                        rd_row <= '0;
                        rd_col <= '0;
                    end
                end
                st_proc: begin
                    if (start) begin
                        issue <= 1'b1;
                    end else if (issue) begin
                        if (scan_end) begin
                            issue <= 1'b0;
                        end
                        if (rd_col == last_coord) begin
                            rd_col <= '0;
                            rd_row <= rd_row + 1'b1;   // wraps to 0 after the last row
                        end else begin
                            rd_col <= rd_col + 1'b1;
                        end
                    end
                    if (finish) begin
                        state <= st_load;
                    end
                end
                default: state <= st_load;
            endcase
        end
    end

    // border flags along the compare direction
    assign at_first = wo_class ? (rd_row == '0)         : (rd_col == '0);
    assign at_last  = wo_class ? (rd_row == last_coord) : (rd_col == last_coord);

    // picture address of the sample being issued
    assign top_row    = ipf_pkg::addr_t'(lcu_y_q) * side_a + ipf_pkg::addr_t'(rd_row);
    assign issue_addr = top_row * width_a
                      + ipf_pkg::addr_t'(lcu_x_q) * side_a
                      + ipf_pkg::addr_t'(rd_col);

endmodule

`default_nettype wire

// ==== hw/ipf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipf_top #(
    parameter int lcu_side = 16
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              in_en,
    input  wire ipf_pkg::pixel_t   din,
    input  wire logic [1:0]        ipf_type,
    input  wire logic [4:0]        ipf_band_pos,
    input  wire logic              ipf_wo_class,
    input  wire logic [15:0]       ipf_offset,
    input  wire logic [2:0]        lcu_x,
    input  wire logic [2:0]        lcu_y,
    output logic                   busy,
    output logic                   out_en,
    output ipf_pkg::pixel_t        dout,
    output ipf_pkg::addr_t         dout_addr,
    output logic                   finish
);

    localparam int coord_w = $clog2(lcu_side);

    // buffer <-> controller
    logic               load_done;
    logic               first_write;
    logic               load_done_ack;
    logic [coord_w-1:0] rd_row;
    logic [coord_w-1:0] rd_col;

    // neighbourhood into the filter
    ipf_pkg::pixel_t    centre;
    ipf_pkg::pixel_t    left;
    ipf_pkg::pixel_t    right;
    ipf_pkg::pixel_t    up;
    ipf_pkg::pixel_t    down;

    // controller -> filter
    logic               issue;
    logic               at_first;
    logic               at_last;
    ipf_pkg::addr_t     issue_addr;
    ipf_pkg::ipf_mode_t mode;
    logic               wo_class;
    logic [4:0]         band_pos;
    logic [15:0]        offsets;

    lcu_pixel_buffer #(
        .lcu_side      (lcu_side)
    ) buffer_i (
        .clk           (clk),
        .rst           (rst),
        .in_en         (in_en),
        .busy          (busy),
        .din           (din),
        .rd_row        (rd_row),
        .rd_col        (rd_col),
        .load_done_ack (load_done_ack),
        .load_done     (load_done),
        .first_write   (first_write),
        .centre        (centre),
        .left          (left),
        .right         (right),
        .up            (up),
        .down          (down)
    );

    ipf_scan_ctrl #(
        .lcu_side      (lcu_side)
    ) ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .first_write   (first_write),
        .load_done     (load_done),
        .ipf_type      (ipf_type),
        .ipf_band_pos  (ipf_band_pos),
        .ipf_wo_class  (ipf_wo_class),
        .ipf_offset    (ipf_offset),
        .lcu_x         (lcu_x),
        .lcu_y         (lcu_y),
        .busy          (busy),
        .finish        (finish),
        .load_done_ack (load_done_ack),
        .issue         (issue),
        .at_first      (at_first),
        .at_last       (at_last),
        .rd_row        (rd_row),
        .rd_col        (rd_col),
        .issue_addr    (issue_addr),
        .mode          (mode),
        .wo_class      (wo_class),
        .band_pos      (band_pos),
        .offsets       (offsets)
    );

    ipf_sample_filter filter_i (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .at_first      (at_first),
        .at_last       (at_last),
        .mode          (mode),
        .wo_class      (wo_class),
        .band_pos      (band_pos),
        .offsets       (offsets),
        .issue_addr    (issue_addr),
        .centre        (centre),
        .left          (left),
        .right         (right),
        .up            (up),
        .down          (down),
        .out_en        (out_en),
        .dout          (dout),
        .dout_addr     (dout_addr)
    );

endmodule

`default_nettype wire

// ==== hw/lcu_pixel_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcu_pixel_buffer #(
    parameter int lcu_side = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          in_en,
    input  wire logic                          busy,
    input  wire ipf_pkg::pixel_t               din,
    input  wire logic [$clog2(lcu_side)-1:0]   rd_row,
    input  wire logic [$clog2(lcu_side)-1:0]   rd_col,
    input  wire logic                          load_done_ack,
    output logic                               load_done,
    output logic                               first_write,
    output ipf_pkg::pixel_t                    centre,
    output ipf_pkg::pixel_t                    left,
    output ipf_pkg::pixel_t                    right,
    output ipf_pkg::pixel_t                    up,
    output ipf_pkg::pixel_t                    down
);

    localparam int coord_w = $clog2(lcu_side);
    localparam int idx_w   = 2 * coord_w;

    localparam logic [coord_w-1:0] last_coord = coord_w'(lcu_side - 1);
    localparam logic [idx_w-1:0]   last_ptr   = idx_w'(lcu_side * lcu_side - 1);

    ipf_pkg::pixel_t    mem [lcu_side*lcu_side];
    logic [idx_w-1:0]   wr_ptr;
    logic               wr_accept;

    logic [coord_w-1:0] col_dec;
    logic [coord_w-1:0] col_inc;
    logic [coord_w-1:0] row_dec;
    logic [coord_w-1:0] row_inc;

    // ------------------------------------------------------------------------
    // load side
    // ------------------------------------------------------------------------
    assign wr_accept   = in_en && !busy;              // input dropped while filtering
    assign first_write = wr_accept && (wr_ptr == '0);
    assign load_done   = wr_accept && (wr_ptr == last_ptr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (load_done_ack) begin
            wr_ptr <= '0;                             // ready for next LCU
        end else if (wr_accept && !load_done) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= din;
        end
    end

    // ------------------------------------------------------------------------
    // neighbourhood read with the centre standing in past the border
    // ------------------------------------------------------------------------
    assign col_dec = rd_col - 1'b1;
    assign col_inc = rd_col + 1'b1;
    assign row_dec = rd_row - 1'b1;
    assign row_inc = rd_row + 1'b1;

    assign centre = mem[{rd_row, rd_col}];
    assign left   = (rd_col == '0)         ? centre : mem[{rd_row, col_dec}];
    assign right  = (rd_col == last_coord) ? centre : mem[{rd_row, col_inc}];
    assign up     = (rd_row == '0)         ? centre : mem[{row_dec, rd_col}];
    assign down   = (rd_row == last_coord) ? centre : mem[{row_inc, rd_col}];

endmodule

`default_nettype wire

// ==== testbench/ipf_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipf_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic busy,
    input wire logic out_en,
    input wire logic finish
);

    // ------------------------------------------------------------------------
    // output framing
    // ------------------------------------------------------------------------
    out_en_in_busy: assert property (
        @(posedge clk) disable iff (rst) out_en |-> busy
    ) else $error("out_en outside the process phase");

    finish_with_out_en: assert property (
        @(posedge clk) disable iff (rst) finish |-> out_en
    ) else $error("finish without a matching out_en");

    // busy drops right after finish and never elsewhere
    busy_fall_after_finish: assert property (
        @(posedge clk) disable iff (rst) $fell(busy) |-> $past(finish)
    ) else $error("busy fell without finish");

    finish_ends_busy: assert property (
        @(posedge clk) disable iff (rst) finish |=> !busy
    ) else $error("busy still high after finish");

endmodule

bind ipf_top ipf_properties props_i (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .out_en (out_en),
    .finish (finish)
);

`default_nettype wire

// ==== testbench/ipf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipf_tb;

    localparam int lcu_side = 16;
    localparam int n_pix    = lcu_side * lcu_side;
    localparam int n_lcu    = 13;
    localparam int period   = 40;

    // sample pattern kinds for fill_lcu
    localparam int fill_rand   = 0;
    localparam int fill_band   = 1;
    localparam int fill_edge_h = 2;
    localparam int fill_edge_v = 3;

    logic            clk;
    logic            rst;
    logic            in_en;
    ipf_pkg::pixel_t din;
    logic [1:0]      ipf_type;
    logic [4:0]      ipf_band_pos;
    logic            ipf_wo_class;
    logic [15:0]     ipf_offset;
    logic [2:0]      lcu_x;
    logic [2:0]      lcu_y;
    logic            busy;
    logic            out_en;
    logic            finish;
    ipf_pkg::pixel_t dout;
    ipf_pkg::addr_t  dout_addr;

    // testbench copy of the LCU and the configuration it was loaded with
    logic [7:0]  ref_pix [n_pix];
    int          cfg_type;
    int          cfg_band;
    int          cfg_wo;
    int          cfg_x;
    int          cfg_y;
    logic [15:0] cfg_off;

    // min, max, concave, convex and flat runs along the compare direction
    int edge_seq [16] = '{100, 40, 100, 160, 100, 100, 100, 140,
                          150, 150, 130, 100, 0, 255, 0, 250};

    logic [31:0] lcg_state   = 32'd77;
    int          errors      = 0;
    int          checks      = 0;
    int          out_count   = 0;
    int          done_count  = 0;
    int          total_out   = 0;
    logic        prev_busy   = 1'b0;
    logic        prev_finish = 1'b0;

    ipf_top #(
        .lcu_side     (lcu_side)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_wo_class (ipf_wo_class),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .busy         (busy),
        .out_en       (out_en),
        .dout         (dout),
        .dout_addr    (dout_addr),
        .finish       (finish)
    );

    always #(period / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];                  // upper half of the state
    endfunction

    function automatic int offset_field(input logic [15:0] word, input int k);
        int v;
        v = int'((word >> (12 - 4 * k)) & 16'hf);
        if (v >= 8) v = v - 16;                   // signed nibble
        return v;
    endfunction

    function automatic int expected_sample(input int row, input int col);
        int  c;
        int  a;
        int  b;
        int  k;
        int  band;
        int  res;
        bit  inner;
        c = ref_pix[row * lcu_side + col];
        k = -1;
        if (cfg_type == 1) begin
            band = c / 8;
            if (band >= cfg_band && band < cfg_band + 4) k = band - cfg_band;
        end else if (cfg_type == 2) begin
            inner = cfg_wo ? (row > 0 && row < lcu_side - 1)
                           : (col > 0 && col < lcu_side - 1);
            if (inner) begin
                if (cfg_wo) begin
                    a = ref_pix[(row - 1) * lcu_side + col];
                    b = ref_pix[(row + 1) * lcu_side + col];
                end else begin
                    a = ref_pix[row * lcu_side + col - 1];
                    b = ref_pix[row * lcu_side + col + 1];
                end
                if (c < a && c < b) k = 0;
                else if (c > a && c > b) k = 3;
                else if (2 * c < a + b) k = 1;
                else if (2 * c > a + b) k = 2;
            end
        end
        res = c;
        if (k >= 0) res = c + offset_field(cfg_off, k);
        if (res < 0) res = 0;
        if (res > 255) res = 255;
        return res;
    endfunction

    function automatic int expected_addr(input int row, input int col);
        return ((cfg_y * lcu_side + row) * ipf_pkg::img_width
                + cfg_x * lcu_side + col) % 16384;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("error: %s at %0t", what, $time);
    endtask

    task automatic fill_lcu(input int fill);
        int along;
        int across;
        int v;
        for (int i = 0; i < n_pix; i++) begin
            along  = (fill == fill_edge_v) ? i / lcu_side : i % lcu_side;
            across = (fill == fill_edge_v) ? i % lcu_side : i / lcu_side;
            v = int'(next_rand()) % 256;
            if (fill == fill_band && i % 4 != 3) v = cfg_band * 8 + v % 32;
            if (fill == fill_edge_h || fill == fill_edge_v) begin
                v = edge_seq[(along + 3 * across) % 16];
            end
            ref_pix[i] = (v > 255) ? 8'd255 : 8'(v);
        end
    endtask

    // waits for finish and pushes stray samples while busy when junk is set
    task automatic wait_done(input bit junk);
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen  = finish;
            in_en = junk && busy;
            din   = 8'(next_rand());
        end
        @(negedge clk);
        in_en = 1'b0;
        if (busy) note_failure("busy still high one cycle after finish");
        check_value("out_en count", done_count, n_pix);
    endtask

    task automatic run_lcu(input int typ, input int band, input int wo, input logic [15:0] off,
                           input int x, input int y, input int fill, input bit junk);
        logic [15:0] r;
        cfg_type   = typ;
        cfg_band   = band;
        cfg_wo     = wo;
        cfg_off    = off;
        cfg_x      = x;
        cfg_y      = y;
        done_count = 0;
        fill_lcu(fill);
        for (int i = 0; i < n_pix; i++) begin
            @(negedge clk);
            in_en = 1'b1;
            din   = ref_pix[i];
            if (i == 0) begin
                ipf_type     = typ[1:0];
                ipf_band_pos = band[4:0];
                ipf_wo_class = wo[0];
                ipf_offset   = off;
                lcu_x        = x[2:0];
                lcu_y        = y[2:0];
            end else begin
                r = next_rand();                  // config is don't care after sample 0
                {ipf_type, ipf_band_pos, ipf_wo_class, lcu_x, lcu_y} = r[13:0];
                ipf_offset = next_rand();
            end
        end
        wait_done(junk);
    endtask

    // ------------------------------------------------------------------------
    // output compare
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        int row;
        int col;
        if (!rst) begin
            if (out_en && !busy) note_failure("out_en seen while busy is low");
            if (finish && !out_en) note_failure("finish seen without out_en");
            if (prev_busy && !busy && !prev_finish) note_failure("busy fell without finish");
            if (out_en && out_count >= n_pix) begin
                note_failure("more out_en pulses than samples in the LCU");
            end else if (out_en) begin
                row = out_count / lcu_side;
                col = out_count % lcu_side;
                total_out++;
                check_value("dout", dout, expected_sample(row, col));
                check_value("dout_addr", dout_addr, expected_addr(row, col));
                check_value("finish", finish, out_count == n_pix - 1);
                if (finish) begin
                    done_count = out_count + 1;
                    out_count  = 0;
                end else begin
                    out_count++;
                end
            end
            prev_busy   = busy;
            prev_finish = finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = '0;
        ipf_band_pos = '0;
        ipf_wo_class = 1'b0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // off mode with both codes
        run_lcu(0, 0, 0, next_rand(), 0, 0, fill_rand, 1'b0);
        run_lcu(3, 7, 1, next_rand(), 5, 2, fill_rand, 1'b1);
        run_lcu(0, 3, 0, 16'h7777, 7, 7, fill_rand, 1'b0);
        // band offset with low clip and high clip and bands past 31
        run_lcu(1, 0, 0, 16'h8f7a, 1, 0, fill_band, 1'b0);
        run_lcu(1, 28, 0, 16'h1357, 2, 3, fill_band, 1'b1);
        run_lcu(1, 30, 1, 16'h7777, 3, 1, fill_band, 1'b0);
        run_lcu(1, int'(next_rand()) % 32, 0, next_rand(), 6, 0, fill_rand, 1'b0);
        // edge offset horizontal then vertical
        run_lcu(2, 0, 0, 16'ha27c, 4, 4, fill_edge_h, 1'b0);
        run_lcu(2, 0, 0, 16'h35f7, 0, 6, fill_edge_h, 1'b1);
        run_lcu(2, 0, 1, 16'ha27c, 1, 5, fill_edge_v, 1'b0);
        run_lcu(2, 0, 1, 16'h35f7, 6, 5, fill_edge_v, 1'b1);
        run_lcu(2, 0, 0, next_rand(), 2, 7, fill_rand, 1'b0);
        run_lcu(2, 0, 1, next_rand(), 3, 3, fill_rand, 1'b0);

        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d, out_en pulses %0d", checks, errors, total_out);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // each LCU needs about two passes over its samples
    initial begin
        #(period * (8 + n_lcu * 2 * n_pix + 500));
        $display("timeout: the run did not complete in the expected time");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
